//--- design/ball_apb_regs.sv
`timescale 1ns/1ps
`include "ball_settings.svh"

module ball_apb_regs (
	input  logic                    vsync,
	input  logic                    reset,
	input  ball_pkg::apb_req_t      apb,
	input  ball_pkg::sprite_t       sprite,
	input  ball_pkg::bounce_cnt_t   bounces,
	output logic [`BALL_APB_DW-1:0] prdata,
	output logic                    pready,
	output ball_pkg::ctrl_t         ctrl
);

	localparam ball_pkg::vel_t VEL_INIT = ball_pkg::vel_t'(`BALL_VEL_INIT);
	localparam int VW = $bits(ball_pkg::vel_t);
	localparam int CW = $bits(ball_pkg::coord_t);

	logic           wr_en;
	logic           run;
	logic           restart;
	ball_pkg::vel_t vel_x;
	ball_pkg::vel_t vel_y;

	function automatic logic [`BALL_APB_DW-1:0] sext_vel(input ball_pkg::vel_t v);
		logic [`BALL_APB_DW-1:0] r;
		r = {{(`BALL_APB_DW - VW){v[VW-1]}}, v};
		return r;
	endfunction

	// slave never stalls
	assign pready = 1'b1;

	// write lands on the edge that closes the access phase
	assign wr_en = apb.psel && apb.penable && apb.pwrite;

	always_ff @(posedge vsync or posedge reset) begin
		if (reset) begin
			run   <= 1'b0;
			vel_x <= VEL_INIT;
			vel_y <= VEL_INIT;
		end else if (wr_en) begin
			case (apb.paddr)
				`BALL_REG_CTRL: begin
					run <= apb.pwdata[0];
				end
				`BALL_REG_VEL_X: begin
					vel_x <= ball_pkg::vel_t'(apb.pwdata[VW-1:0]);
				end
				`BALL_REG_VEL_Y: begin
					vel_y <= ball_pkg::vel_t'(apb.pwdata[VW-1:0]);
				end
				default: begin
				end
			endcase
		end
	end

	// bit 1 of ctrl is write-one, becomes a single cycle pulse
	always_ff @(posedge vsync or posedge reset) begin
		if (reset) begin
			restart <= 1'b0;
		end else begin
			restart <= wr_en && (apb.paddr == `BALL_REG_CTRL) && apb.pwdata[1];
		end
	end

	assign ctrl.run     = run;
	assign ctrl.restart = restart;
	assign ctrl.vel_x   = vel_x;
	assign ctrl.vel_y   = vel_y;

	// read data valid during setup and access
	always_comb begin
		prdata = '0;
		if (apb.psel && !apb.pwrite) begin
			case (apb.paddr)
				`BALL_REG_CTRL:   prdata[0] = run;
				`BALL_REG_VEL_X:  prdata = sext_vel(vel_x);
				`BALL_REG_VEL_Y:  prdata = sext_vel(vel_y);
				`BALL_REG_POS: begin
					prdata[CW-1:0]     = sprite.left;
					prdata[16+CW-1:16] = sprite.top;
				end
				`BALL_REG_BOUNCE: prdata[$bits(bounces)-1:0] = bounces;
				default:          prdata = '0;
			endcase
		end
	end

endmodule

//--- design/ball_motion.sv
`timescale 1ns/1ps
`include "ball_settings.svh"

module ball_motion (
	input  logic              vsync,
	input  logic              reset,
	input  ball_pkg::ctrl_t   ctrl,
	output ball_pkg::motion_t motion
);

	typedef enum logic {
		ST_IDLE,
		ST_MOVING
	} motion_state_t;

	localparam ball_pkg::coord_t X_INIT = ball_pkg::coord_t'(`BALL_X_INIT);
	localparam ball_pkg::coord_t Y_INIT = ball_pkg::coord_t'(`BALL_Y_INIT);
	localparam ball_pkg::vel_t VEL_INIT = ball_pkg::vel_t'(`BALL_VEL_INIT);

	// reflection limits, low edge is shared by both axes
	localparam ball_pkg::coord_t EDGE_LO = ball_pkg::coord_t'(`BALL_SIZE);
	localparam ball_pkg::coord_t X_HI = ball_pkg::coord_t'(`BALL_SCREEN_W - `BALL_SIZE);
	localparam ball_pkg::coord_t Y_HI = ball_pkg::coord_t'(`BALL_SCREEN_H - `BALL_SIZE);

	motion_state_t    state;
	ball_pkg::vel_t   vel_x;
	ball_pkg::vel_t   vel_y;
	ball_pkg::coord_t x_step;
	ball_pkg::coord_t y_step;
	logic             bounce_x;
	logic             bounce_y;

	// run selects the state directly so the step lands on this edge
	assign state = ctrl.run ? ST_MOVING : ST_IDLE;

	// add velocity, wraps at 10 bits
	assign x_step = motion.x + ball_pkg::coord_t'(vel_x);
	assign y_step = motion.y + ball_pkg::coord_t'(vel_y);

	// a wrapped negative step lands above the high limit and reflects too
	assign bounce_x = (x_step <= EDGE_LO) || (x_step >= X_HI);
	assign bounce_y = (y_step <= EDGE_LO) || (y_step >= Y_HI);

	always_ff @(posedge vsync or posedge reset) begin
		if (reset) begin
			motion.x     <= X_INIT;
			motion.y     <= Y_INIT;
			motion.hit_x <= 1'b0;
			motion.hit_y <= 1'b0;
			vel_x        <= VEL_INIT;
			vel_y        <= VEL_INIT;
		end else if (ctrl.restart) begin
			motion.x     <= X_INIT;
			motion.y     <= Y_INIT;
			motion.hit_x <= 1'b0;
			motion.hit_y <= 1'b0;
			vel_x        <= ctrl.vel_x;
			vel_y        <= ctrl.vel_y;
		end else if (state == ST_MOVING) begin
			motion.x     <= x_step;
			motion.y     <= y_step;
			motion.hit_x <= bounce_x;
			motion.hit_y <= bounce_y;
			if (bounce_x) begin
				vel_x <= -vel_x;
			end
			if (bounce_y) begin
				vel_y <= -vel_y;
			end
		end else begin
			// paused, position and velocity hold
			motion.hit_x <= 1'b0;
			motion.hit_y <= 1'b0;
		end
	end

endmodule

//--- design/ball_pkg.sv
`include "ball_settings.svh"

package ball_pkg;

	// screen coordinate, unsigned
	typedef logic [9:0] coord_t;

	// two's complement step per frame
	typedef logic signed [9:0] vel_t;

	typedef logic [15:0] bounce_cnt_t;

	typedef struct packed {
		logic [7:0]             paddr;
		logic                   psel;
		logic                   penable;
		logic                   pwrite;
		logic [`BALL_APB_DW-1:0] pwdata;
	} apb_req_t;

	// register block to motion engine
	typedef struct packed {
		logic run;
		logic restart;
		vel_t vel_x;
		vel_t vel_y;
	} ctrl_t;

	// one computed frame
	typedef struct packed {
		coord_t x;
		coord_t y;
		logic   hit_x;
		logic   hit_y;
	} motion_t;

	// bounding box, inclusive corners
	typedef struct packed {
		coord_t left;
		coord_t top;
		coord_t right;
		coord_t bottom;
	} sprite_t;

endpackage

//--- design/ball_settings.svh
`ifndef BALL_SETTINGS_SVH
`define BALL_SETTINGS_SVH

// visible screen area in pixels
`define BALL_SCREEN_W 640
`define BALL_SCREEN_H 480

// square ball, edge length in pixels
`define BALL_SIZE 4

// start position, ball centred on screen
`define BALL_X_INIT 316
`define BALL_Y_INIT 236
`define BALL_VEL_INIT 2

// apb data bus
`define BALL_APB_DW 32

// register map
`define BALL_REG_CTRL 8'h00
`define BALL_REG_VEL_X 8'h04
`define BALL_REG_VEL_Y 8'h08
`define BALL_REG_POS 8'h0C
`define BALL_REG_BOUNCE 8'h10

`endif

//--- design/ball_sprite_out.sv
`timescale 1ns/1ps
`include "ball_settings.svh"

module ball_sprite_out (
	input  logic                  vsync,
	input  logic                  reset,
	input  logic                  restart,
	input  ball_pkg::motion_t     motion,
	output ball_pkg::sprite_t     sprite,
	output ball_pkg::bounce_cnt_t bounces
);

	localparam ball_pkg::coord_t X_INIT = ball_pkg::coord_t'(`BALL_X_INIT);
	localparam ball_pkg::coord_t Y_INIT = ball_pkg::coord_t'(`BALL_Y_INIT);
	localparam ball_pkg::coord_t SPAN = ball_pkg::coord_t'(`BALL_SIZE - 1);
	localparam int BW = $bits(ball_pkg::bounce_cnt_t);

	// one extra bit catches the overflow
	logic [BW:0] bounce_sum;

	assign bounce_sum = {1'b0, bounces} + BW'(motion.hit_x) + BW'(motion.hit_y);

	// box for the pixel-rate renderer, inclusive corners
	always_ff @(posedge vsync or posedge reset) begin
		if (reset) begin
			sprite.left   <= X_INIT;
			sprite.top    <= Y_INIT;
			sprite.right  <= X_INIT + SPAN;
			sprite.bottom <= Y_INIT + SPAN;
		end else begin
			sprite.left   <= motion.x;
			sprite.top    <= motion.y;
			sprite.right  <= motion.x + SPAN;
			sprite.bottom <= motion.y + SPAN;
		end
	end

	// saturating bounce count, both axes may hit in one frame
	always_ff @(posedge vsync or posedge reset) begin
		if (reset) begin
			bounces <= '0;
		end else if (restart) begin
			bounces <= '0;
		end else if (bounce_sum[BW]) begin
			bounces <= '1;
		end else begin
			bounces <= bounce_sum[BW-1:0];
		end
	end

endmodule

//--- design/ball_top.sv
`timescale 1ns/1ps
`include "ball_settings.svh"

module ball_top (
	input  logic                    vsync,
	input  logic                    reset,
	input  ball_pkg::apb_req_t      apb,
	output logic [`BALL_APB_DW-1:0] prdata,
	output logic                    pready,
	output ball_pkg::sprite_t       sprite,
	output ball_pkg::bounce_cnt_t   bounces
);

	ball_pkg::ctrl_t   ctrl;
	ball_pkg::motion_t motion;

	// registers, status comes back from the output stage
	ball_apb_regs ball_apb_regs_i (
		.vsync   (vsync),
		.reset   (reset),
		.apb     (apb),
		.sprite  (sprite),
		.bounces (bounces),
		.prdata  (prdata),
		.pready  (pready),
		.ctrl    (ctrl)
	);

	// one step per frame
	ball_motion ball_motion_i (
		.vsync  (vsync),
		.reset  (reset),
		.ctrl   (ctrl),
		.motion (motion)
	);

	// sprite box lags motion by one frame
	ball_sprite_out ball_sprite_out_i (
		.vsync   (vsync),
		.reset   (reset),
		.restart (ctrl.restart),
		.motion  (motion),
		.sprite  (sprite),
		.bounces (bounces)
	);

endmodule

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module ball_tb -f vlog.f || exit 1
out="$(./obj_dir/Vball_tb)"
echo "$out"
echo "$out" | grep -qF "Simulation completed successfully" && echo "PASS" \
	|| { echo "FAIL"; exit 1; }

//--- verification/ball_chk.sv
`timescale 1ns/1ps
`include "ball_settings.svh"

module ball_chk (
	input logic              vsync,
	input logic              reset,
	input ball_pkg::ctrl_t   ctrl,
	input ball_pkg::motion_t motion,
	input ball_pkg::vel_t    vel_x,
	input ball_pkg::vel_t    vel_y
);

	// the ball may overshoot an edge by less than its size before it turns
	localparam ball_pkg::coord_t X_LIMIT = ball_pkg::coord_t'(`BALL_SCREEN_W + `BALL_SIZE);
	localparam ball_pkg::coord_t Y_LIMIT = ball_pkg::coord_t'(`BALL_SCREEN_H + `BALL_SIZE);
	// wrapped values just below zero
	localparam ball_pkg::coord_t WRAP_LO = ball_pkg::coord_t'(1024 - `BALL_SIZE);

	restart_single: assert property (@(posedge vsync) disable iff (reset)
		ctrl.restart |=> !ctrl.restart)
		else $error("restart pulse lasted more than one cycle");

	x_on_screen: assert property (@(posedge vsync) disable iff (reset)
		(motion.x < X_LIMIT) || (motion.x >= WRAP_LO))
		else $error("ball x %0d is off the screen", motion.x);

	y_on_screen: assert property (@(posedge vsync) disable iff (reset)
		(motion.y < Y_LIMIT) || (motion.y >= WRAP_LO))
		else $error("ball y %0d is off the screen", motion.y);

	vel_x_change: assert property (@(posedge vsync) disable iff (reset)
		!$stable(vel_x) |-> ($past(ctrl.restart) || motion.hit_x))
		else $error("vel_x changed without restart or hit");

	vel_y_change: assert property (@(posedge vsync) disable iff (reset)
		!$stable(vel_y) |-> ($past(ctrl.restart) || motion.hit_y))
		else $error("vel_y changed without restart or hit");

endmodule

bind ball_motion ball_chk ball_chk_i (
	.vsync  (vsync),
	.reset  (reset),
	.ctrl   (ctrl),
	.motion (motion),
	.vel_x  (vel_x),
	.vel_y  (vel_y)
);

//--- verification/ball_tb.sv
`timescale 1ns/1ps
`include "ball_settings.svh"

module ball_tb;

	localparam int MOTION_FRAMES = 400;
	localparam int PAUSE_FRAMES = 20;
	localparam int RESUME_FRAMES = 50;
	localparam int RESTART_FRAMES = 100;
	// about twenty bus transfers of up to four cycles each
	localparam int BUS_CYCLES = 4 * 20;
	localparam int WATCHDOG_NS = 8 * (10 + MOTION_FRAMES + PAUSE_FRAMES + RESUME_FRAMES
		+ RESTART_FRAMES + BUS_CYCLES) + 1000;

	localparam ball_pkg::coord_t X_INIT = ball_pkg::coord_t'(`BALL_X_INIT);
	localparam ball_pkg::coord_t Y_INIT = ball_pkg::coord_t'(`BALL_Y_INIT);
	localparam ball_pkg::vel_t VEL_INIT = ball_pkg::vel_t'(`BALL_VEL_INIT);
	localparam ball_pkg::coord_t EDGE_LO = ball_pkg::coord_t'(`BALL_SIZE);
	localparam ball_pkg::coord_t X_HI = ball_pkg::coord_t'(`BALL_SCREEN_W - `BALL_SIZE);
	localparam ball_pkg::coord_t Y_HI = ball_pkg::coord_t'(`BALL_SCREEN_H - `BALL_SIZE);
	localparam ball_pkg::coord_t SPAN = ball_pkg::coord_t'(`BALL_SIZE - 1);

	// expected state of registers, motion stage and output stage
	typedef struct packed {
		logic                  run;
		logic                  restart;
		ball_pkg::vel_t        reg_vx;
		ball_pkg::vel_t        reg_vy;
		ball_pkg::coord_t      x;
		ball_pkg::coord_t      y;
		ball_pkg::vel_t        vx;
		ball_pkg::vel_t        vy;
		logic                  hx;
		logic                  hy;
		ball_pkg::coord_t      left;
		ball_pkg::coord_t      top;
		ball_pkg::bounce_cnt_t count;
	} model_t;

	logic                    vsync;
	logic                    reset;
	ball_pkg::apb_req_t      apb;
	logic [`BALL_APB_DW-1:0] prdata;
	logic                    pready;
	ball_pkg::sprite_t       sprite;
	ball_pkg::bounce_cnt_t   bounces;

	model_t                  model;
	model_t                  snap;
	logic [31:0]             seed;
	logic [`BALL_APB_DW-1:0] rdata;
	string                   test_name;
	int                      test_errs;
	int                      pass_count;
	int                      fail_count;
	ball_pkg::vel_t          vx;
	ball_pkg::vel_t          vy;
	ball_pkg::sprite_t       frozen;
	ball_pkg::bounce_cnt_t   frozen_cnt;

	ball_tb_clock ball_tb_clock_i (
		.vsync (vsync),
		.reset (reset)
	);

	ball_top ball_top_i (
		.vsync   (vsync),
		.reset   (reset),
		.apb     (apb),
		.prdata  (prdata),
		.pready  (pready),
		.sprite  (sprite),
		.bounces (bounces)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [`BALL_APB_DW-1:0] wide_vel(input ball_pkg::vel_t v);
		return {{22{v[9]}}, v};
	endfunction

	function automatic ball_pkg::sprite_t box_of(input ball_pkg::coord_t l,
		input ball_pkg::coord_t t);
		ball_pkg::sprite_t b;
		b.left = l;
		b.top = t;
		b.right = l + SPAN;
		b.bottom = t + SPAN;
		return b;
	endfunction

	function automatic logic hits_edge(input ball_pkg::coord_t p, input ball_pkg::coord_t hi);
		return (p <= EDGE_LO) || (p >= hi);
	endfunction

	function automatic model_t model_reset();
		model_t n;
		n = '0;
		n.reg_vx = VEL_INIT;
		n.reg_vy = VEL_INIT;
		n.x = X_INIT;
		n.y = Y_INIT;
		n.vx = VEL_INIT;
		n.vy = VEL_INIT;
		n.left = X_INIT;
		n.top = Y_INIT;
		return n;
	endfunction

	// one clock edge of the whole design
	function automatic model_t next_frame(input model_t m, input ball_pkg::apb_req_t a);
		model_t n;
		logic   wr;
		int     sum;
		n = m;
		wr = a.psel && a.penable && a.pwrite;
		if (m.restart) begin
			n.x = X_INIT;
			n.y = Y_INIT;
			n.vx = m.reg_vx;
			n.vy = m.reg_vy;
			n.hx = 1'b0;
			n.hy = 1'b0;
		end else if (m.run) begin
			n.x = m.x + ball_pkg::coord_t'(m.vx);
			n.y = m.y + ball_pkg::coord_t'(m.vy);
			n.hx = hits_edge(n.x, X_HI);
			n.hy = hits_edge(n.y, Y_HI);
			if (n.hx) begin
				n.vx = -m.vx;
			end
			if (n.hy) begin
				n.vy = -m.vy;
			end
		end else begin
			n.hx = 1'b0;
			n.hy = 1'b0;
		end
		// output stage trails motion by one edge
		n.left = m.x;
		n.top = m.y;
		sum = int'(m.count) + int'(m.hx) + int'(m.hy);
		if (m.restart) begin
			n.count = '0;
		end else if (sum > 65535) begin
			n.count = '1;
		end else begin
			n.count = ball_pkg::bounce_cnt_t'(sum);
		end
		n.restart = wr && (a.paddr == `BALL_REG_CTRL) && a.pwdata[1];
		if (wr && (a.paddr == `BALL_REG_CTRL)) begin
			n.run = a.pwdata[0];
		end
		if (wr && (a.paddr == `BALL_REG_VEL_X)) begin
			n.reg_vx = ball_pkg::vel_t'(a.pwdata[9:0]);
		end
		if (wr && (a.paddr == `BALL_REG_VEL_Y)) begin
			n.reg_vy = ball_pkg::vel_t'(a.pwdata[9:0]);
		end
		return n;
	endfunction

	// magnitude 1 to 7, random sign
	task automatic draw_vel(output ball_pkg::vel_t v);
		logic [2:0] mag;
		seed = lcg_next(seed);
		mag = seed[18:16];
		if (mag == 3'd0) begin
			mag = 3'd7;
		end
		v = ball_pkg::vel_t'({7'd0, mag});
		if (seed[24]) begin
			v = -v;
		end
	endtask

	task automatic report_mismatch(input string what, input string exp, input string act);
		$display("** Error %s %s: expected %s, actual %s", test_name, what, exp, act);
		test_errs++;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		if (test_errs == 0) begin
			pass_count++;
			$display("test %s passed", test_name);
		end else begin
			fail_count++;
			$display("test %s failed with %0d errors", test_name, test_errs);
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [`BALL_APB_DW-1:0] data);
		ball_pkg::apb_req_t req;
		req = '0;
		req.paddr = addr;
		req.psel = 1'b1;
		req.pwrite = 1'b1;
		req.pwdata = data;
		@(posedge vsync);
		apb <= req;
		@(posedge vsync);
		apb.penable <= 1'b1;
		@(posedge vsync);
		apb <= '0;
	endtask

	// samples read data and the model in the middle of the access phase
	task automatic bus_read(input logic [7:0] addr, output logic [`BALL_APB_DW-1:0] data,
		output model_t at_read);
		ball_pkg::apb_req_t req;
		req = '0;
		req.paddr = addr;
		req.psel = 1'b1;
		@(posedge vsync);
		apb <= req;
		@(posedge vsync);
		apb.penable <= 1'b1;
		@(negedge vsync);
		data = prdata;
		at_read = model;
		if (pready !== 1'b1) begin
			$display("test %s: pready was low during an access phase", test_name);
			test_errs++;
		end
		@(posedge vsync);
		apb <= '0;
	endtask

	task automatic expect_read(input string what, input logic [7:0] addr,
		input logic [`BALL_APB_DW-1:0] exp);
		logic [`BALL_APB_DW-1:0] data;
		model_t                  unused_snap;
		bus_read(addr, data, unused_snap);
		if (data !== exp) begin
			report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", data));
		end
	endtask

	always @(posedge vsync or posedge reset) begin
		if (reset) begin
			model = model_reset();
		end else begin
			model = next_frame(model, apb);
		end
	end

	// outputs settle between edges
	always @(negedge vsync) begin
		if (reset === 1'b0) begin
			if (sprite !== box_of(model.left, model.top)) begin
				report_mismatch("sprite", $sformatf("%h", box_of(model.left, model.top)),
					$sformatf("%h", sprite));
			end
			if (bounces !== model.count) begin
				report_mismatch("bounces", $sformatf("%h", model.count),
					$sformatf("%h", bounces));
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, simulation hung");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		apb = '0;
		seed = 32'd30309;
		pass_count = 0;
		fail_count = 0;
		start_test("reset");
		@(negedge reset);
		@(posedge vsync);

		@(negedge vsync);
		if (sprite !== box_of(X_INIT, Y_INIT)) begin
			report_mismatch("initial box", $sformatf("%h", box_of(X_INIT, Y_INIT)),
				$sformatf("%h", sprite));
		end
		if (bounces !== '0) begin
			report_mismatch("initial count", "0000", $sformatf("%h", bounces));
		end
		expect_read("ctrl", `BALL_REG_CTRL, '0);
		expect_read("vel_x", `BALL_REG_VEL_X, wide_vel(VEL_INIT));
		expect_read("vel_y", `BALL_REG_VEL_Y, wide_vel(VEL_INIT));
		finish_test();

		start_test("registers");
		draw_vel(vx);
		draw_vel(vy);
		apb_write(`BALL_REG_VEL_X, wide_vel(vx));
		apb_write(`BALL_REG_VEL_Y, wide_vel(vy));
		expect_read("vel_x", `BALL_REG_VEL_X, wide_vel(vx));
		expect_read("vel_y", `BALL_REG_VEL_Y, wide_vel(vy));
		// run still 0, ball stays at the start
		expect_read("pos", `BALL_REG_POS, {6'd0, Y_INIT, 6'd0, X_INIT});
		finish_test();

		start_test("motion");
		draw_vel(vx);
		draw_vel(vy);
		apb_write(`BALL_REG_VEL_X, wide_vel(vx));
		apb_write(`BALL_REG_VEL_Y, wide_vel(vy));
		apb_write(`BALL_REG_CTRL, 32'h3);
		repeat (MOTION_FRAMES) @(posedge vsync);
		finish_test();

		start_test("bounce");
		bus_read(`BALL_REG_BOUNCE, rdata, snap);
		if (rdata !== {16'd0, snap.count}) begin
			report_mismatch("bounce register", $sformatf("%h", {16'd0, snap.count}),
				$sformatf("%h", rdata));
		end
		@(negedge vsync);
		if (bounces !== model.count) begin
			report_mismatch("bounce port", $sformatf("%h", model.count),
				$sformatf("%h", bounces));
		end
		if (model.count == '0) begin
			$display("test %s: the ball never reached an edge during the run", test_name);
			test_errs++;
		end
		finish_test();

		start_test("pause");
		apb_write(`BALL_REG_CTRL, 32'h0);
		// last step drains through motion and the output stage
		repeat (2) @(posedge vsync);
		@(negedge vsync);
		frozen = box_of(model.left, model.top);
		frozen_cnt = model.count;
		repeat (PAUSE_FRAMES) @(posedge vsync);
		@(negedge vsync);
		if (sprite !== frozen) begin
			report_mismatch("frozen box", $sformatf("%h", frozen), $sformatf("%h", sprite));
		end
		if (bounces !== frozen_cnt) begin
			report_mismatch("frozen count", $sformatf("%h", frozen_cnt),
				$sformatf("%h", bounces));
		end
		apb_write(`BALL_REG_CTRL, 32'h1);
		repeat (RESUME_FRAMES) @(posedge vsync);
		finish_test();

		start_test("restart");
		draw_vel(vx);
		draw_vel(vy);
		apb_write(`BALL_REG_VEL_X, wide_vel(vx));
		apb_write(`BALL_REG_VEL_Y, wide_vel(vy));
		apb_write(`BALL_REG_CTRL, 32'h3);
		// pulse hits motion on the next edge, the box one edge later
		repeat (2) @(posedge vsync);
		@(negedge vsync);
		if (sprite !== box_of(X_INIT, Y_INIT)) begin
			report_mismatch("restart box", $sformatf("%h", box_of(X_INIT, Y_INIT)),
				$sformatf("%h", sprite));
		end
		if (bounces !== '0) begin
			report_mismatch("restart count", "0000", $sformatf("%h", bounces));
		end
		@(negedge vsync);
		if (sprite.left !== X_INIT + ball_pkg::coord_t'(vx)) begin
			report_mismatch("first x", $sformatf("%h", X_INIT + ball_pkg::coord_t'(vx)),
				$sformatf("%h", sprite.left));
		end
		if (sprite.top !== Y_INIT + ball_pkg::coord_t'(vy)) begin
			report_mismatch("first y", $sformatf("%h", Y_INIT + ball_pkg::coord_t'(vy)),
				$sformatf("%h", sprite.top));
		end
		repeat (RESTART_FRAMES) @(posedge vsync);
		finish_test();

		$display("%0d tests passed, %0d tests failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- verification/ball_tb_clock.sv
`timescale 1ns/1ps

module ball_tb_clock (
	output logic vsync,
	output logic reset
);

	// one frame every 8 ns
	initial begin
		vsync = 1'b0;
		forever #4 vsync = ~vsync;
	end

	// reset held for the first five frames
	initial begin
		reset = 1'b1;
		repeat (5) @(posedge vsync);
		reset <= 1'b0;
	end

endmodule

//--- vlog.f
+incdir+design
design/ball_pkg.sv
design/ball_apb_regs.sv
design/ball_motion.sv
design/ball_sprite_out.sv
design/ball_top.sv
verification/ball_tb_clock.sv
verification/ball_chk.sv
verification/ball_tb.sv
